// File: Makefile
SIM   := verilator
FLAGS := --binary --timing --assert
TOP   := tb_core
FLIST := flist.f
OBJ   := obj_dir
BIN   := $(OBJ)/V$(TOP)
LOG   := sim.log
SRCS  := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: flist.f
rv_pkg.sv
rv_alu.sv
rv_regfile.sv
rv_imm_gen.sv
rv_ctrl.sv
rv_fetch.sv
rv_core.sv
tb_core.sv

// File: rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
    input  rv_pkg::alu_op_e         op,
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    zero
);
    import rv_pkg::*;

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            default: result = '0;
        endcase
    end

    assign zero = (result == '0); // bne taken when low

endmodule

// File: rv_core.sv
`timescale 1ns/100ps

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [rv_pkg::xlen-1:0] imem_data,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    output logic                    store_en,
    output logic [rv_pkg::xlen-1:0] store_addr,
    output logic [rv_pkg::xlen-1:0] store_data,
    output logic                    halted,
    output logic                    illegal_inst
);
    import rv_pkg::*;

    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] reg1_raddr;
    logic [reg_addr_w-1:0] reg2_raddr;
    logic [reg_addr_w-1:0] reg_waddr;
    logic                  reg_wen;
    imm_sel_e              imm_sel;
    alu_op_e               alu_op;
    src_sel_e              src_sel;
    logic                  branch;
    logic                  jump;
    logic                  jalr;
    logic                  store;
    logic                  halt_req;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       opnd_a;
    logic [xlen-1:0]       opnd_b;
    logic [xlen-1:0]       result;
    logic                  zero;
    logic [xlen-1:0]       jalr_target;

    rv_fetch #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .branch      (branch),
        .jump        (jump),
        .jalr        (jalr),
        .zero        (zero),
        .halt_req    (halt_req),
        .imm         (imm),
        .jalr_target (jalr_target),
        .pc          (pc),
        .halted      (halted)
    );

    rv_ctrl u_ctrl (
        .inst       (inst_t'(imem_data)),
        .reg_wen    (reg_wen),
        .reg_waddr  (reg_waddr),
        .reg1_raddr (reg1_raddr),
        .reg2_raddr (reg2_raddr),
        .imm_sel    (imm_sel),
        .alu_op     (alu_op),
        .src_sel    (src_sel),
        .branch     (branch),
        .jump       (jump),
        .jalr       (jalr),
        .store      (store),
        .halt_req   (halt_req),
        .illegal    (illegal_inst)
    );

    rv_imm_gen u_imm_gen (
        .inst    (inst_t'(imem_data)),
        .imm_sel (imm_sel),
        .imm     (imm)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (reg1_raddr),
        .raddr2 (reg2_raddr),
        .waddr  (reg_waddr),
        .wen    (reg_wen && !halted),
        .wdata  (result),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // operand muxes
    assign opnd_a = (src_sel == src_pc_imm || src_sel == src_pc_four) ? pc : rs1_data;

    always_comb begin
        case (src_sel)
            src_reg:     opnd_b = rs2_data;
            src_pc_four: opnd_b = xlen'(4);
            default:     opnd_b = imm;
        endcase
    end

    rv_alu u_alu (
        .op     (alu_op),
        .a      (opnd_a),
        .b      (opnd_b),
        .result (result),
        .zero   (zero)
    );

    // alu busy with the link value, target needs its own adder
    assign jalr_target = rs1_data + imm;

    assign imem_addr  = pc;
    assign store_en   = store && !halted && arst_n;
    assign store_addr = result;
    assign store_data = rs2_data;

endmodule

// File: rv_ctrl.sv
`timescale 1ns/100ps

module rv_ctrl (
    input  rv_pkg::inst_t                   inst,
    output logic                            reg_wen,
    output logic [rv_pkg::reg_addr_w-1:0]   reg_waddr,
    output logic [rv_pkg::reg_addr_w-1:0]   reg1_raddr,
    output logic [rv_pkg::reg_addr_w-1:0]   reg2_raddr,
    output rv_pkg::imm_sel_e                imm_sel,
    output rv_pkg::alu_op_e                 alu_op,
    output rv_pkg::src_sel_e                src_sel,
    output logic                            branch,
    output logic                            jump,
    output logic                            jalr,
    output logic                            store,
    output logic                            halt_req,
    output logic                            illegal
);
    import rv_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;

    // common fields sit at the same place in every format
    assign opcode = inst.r_fmt.opcode;
    assign funct3 = inst.r_fmt.funct3;
    assign funct7 = inst.r_fmt.funct7;
    assign rd     = inst.r_fmt.rd;
    assign rs1    = inst.r_fmt.rs1;
    assign rs2    = inst.r_fmt.rs2;

    always_comb begin
        reg_wen    = 1'b0;
        reg_waddr  = '0;
        reg1_raddr = '0;
        reg2_raddr = '0;
        imm_sel    = imm_i;
        alu_op     = alu_and;
        src_sel    = src_reg;
        branch     = 1'b0;
        jump       = 1'b0;
        jalr       = 1'b0;
        store      = 1'b0;
        halt_req   = 1'b0;
        illegal    = 1'b0;
        case (opcode)
            op_r: begin
                if (funct3 == f3_add_sub && (funct7 == f7_add || funct7 == f7_sub)) begin
                    reg_wen    = 1'b1;
                    reg_waddr  = rd;
                    reg1_raddr = rs1;
                    reg2_raddr = rs2;
                    alu_op     = (funct7 == f7_sub) ? alu_sub : alu_add;
                end else begin
                    illegal = 1'b1;
                end
            end
            op_i: begin
                if (funct3 == f3_addi) begin
                    reg_wen    = 1'b1;
                    reg_waddr  = rd;
                    reg1_raddr = rs1;
                    alu_op     = alu_add;
                    src_sel    = src_imm;
                end else begin
                    illegal = 1'b1;
                end
            end
            op_b: begin
                if (funct3 == f3_bne) begin
                    reg1_raddr = rs1;
                    reg2_raddr = rs2;
                    imm_sel    = imm_b;
                    alu_op     = alu_sub; // zero flag compares rs1, rs2
                    branch     = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            op_s: begin
                if (funct3 == f3_sw) begin
                    reg1_raddr = rs1;
                    reg2_raddr = rs2; // store data
                    imm_sel    = imm_s;
                    alu_op     = alu_add;
                    src_sel    = src_imm;
                    store      = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            op_jal: begin
                reg_wen   = 1'b1;
                reg_waddr = rd;
                imm_sel   = imm_j;
                alu_op    = alu_add;
                src_sel   = src_pc_four; // link
                jump      = 1'b1;
            end
            op_jalr: begin
                if (funct3 == f3_jalr) begin
                    reg_wen    = 1'b1;
                    reg_waddr  = rd;
                    reg1_raddr = rs1;
                    imm_sel    = imm_i;
                    alu_op     = alu_add;
                    src_sel    = src_pc_four;
                    jump       = 1'b1;
                    jalr       = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            op_lui: begin
                reg_wen   = 1'b1;
                reg_waddr = rd;
                imm_sel   = imm_u;
                alu_op    = alu_add;
                src_sel   = src_imm; // x0 + imm
            end
            op_auipc: begin
                reg_wen   = 1'b1;
                reg_waddr = rd;
                imm_sel   = imm_u;
                alu_op    = alu_add;
                src_sel   = src_pc_imm;
            end
            op_system: begin
                if (inst == inst_ebreak) halt_req = 1'b1;
                else                     illegal  = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// File: rv_fetch.sv
`timescale 1ns/100ps

module rv_fetch #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    branch,
    input  logic                    jump,
    input  logic                    jalr,
    input  logic                    zero,
    input  logic                    halt_req,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  logic [rv_pkg::xlen-1:0] jalr_target,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic                    halted
);
    import rv_pkg::*;

    logic [xlen-1:0] next_pc;

    always_comb begin
        if (halt_req || halted)         next_pc = pc;
        else if (jalr)                  next_pc = {jalr_target[xlen-1:1], 1'b0};
        else if (jump || (branch && !zero)) next_pc = pc + imm;
        else                            next_pc = pc + xlen'(4);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else begin
            pc <= next_pc;
            if (halt_req) halted <= 1'b1; // sticky until reset
        end
    end

endmodule

// File: rv_imm_gen.sv
`timescale 1ns/100ps

module rv_imm_gen (
    input  rv_pkg::inst_t           inst,
    input  rv_pkg::imm_sel_e        imm_sel,
    output logic [rv_pkg::xlen-1:0] imm
);
    import rv_pkg::*;

    always_comb begin
        case (imm_sel)
            imm_i: imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            imm_s: imm = {{20{inst.s_fmt.imm_11_5[6]}},
                          inst.s_fmt.imm_11_5,
                          inst.s_fmt.imm_4_0};
            imm_b: imm = {{19{inst.b_fmt.imm_12}},
                          inst.b_fmt.imm_12,
                          inst.b_fmt.imm_11,
                          inst.b_fmt.imm_10_5,
                          inst.b_fmt.imm_4_1,
                          1'b0}; // halfword offset
            imm_u: imm = {inst.u_fmt.imm_31_12, 12'b0};
            imm_j: imm = {{11{inst.j_fmt.imm_20}},
                          inst.j_fmt.imm_20,
                          inst.j_fmt.imm_19_12,
                          inst.j_fmt.imm_11,
                          inst.j_fmt.imm_10_1,
                          1'b0};
            default: imm = '0;
        endcase
    end

endmodule

// File: rv_pkg.sv
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes
    localparam logic [6:0] op_r      = 7'b0110011;
    localparam logic [6:0] op_i      = 7'b0010011;
    localparam logic [6:0] op_s      = 7'b0100011;
    localparam logic [6:0] op_b      = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_addi    = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_sw      = 3'b010;
    localparam logic [2:0] f3_jalr    = 3'b000;

    localparam logic [6:0] f7_add = 7'b0000000;
    localparam logic [6:0] f7_sub = 7'b0100000;

    localparam logic [xlen-1:0] inst_ebreak = 32'h0010_0073;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_sel_e;

    typedef enum logic [1:0] {
        src_reg,     // rs1, rs2
        src_imm,     // rs1, imm
        src_pc_imm,  // pc, imm
        src_pc_four  // pc, 4
    } src_sel_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_t;

endpackage

// File: rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr2,
    input  logic [rv_pkg::reg_addr_w-1:0] waddr,
    input  logic                          wen,
    input  logic [rv_pkg::xlen-1:0]       wdata,
    output logic [rv_pkg::xlen-1:0]       rdata1,
    output logic [rv_pkg::xlen-1:0]       rdata2
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads
    always_comb begin
        rdata1 = '0;
        rdata2 = '0;
        if (raddr1 != '0) rdata1 = regs[raddr1];
        if (raddr2 != '0) rdata2 = regs[raddr2];
    end

endmodule

// File: tb_core.sv
`timescale 1ns/100ps

module tb_core;

    localparam int          prog_words  = 40;
    localparam int          cycle_limit = prog_words * 4 + 20;
    localparam logic [31:0] base_addr   = 32'h0000_0100;
    localparam logic [31:0] illegal_pc  = 32'd108; // word 27
    localparam logic [31:0] ebreak_pc   = 32'd116; // word 29

    logic        clk;
    logic        arst_n;
    logic [31:0] imem_data;
    logic [31:0] imem_addr;
    logic        store_en;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic        halted;
    logic        illegal_inst;

    logic [31:0] imem [0:63];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] front_addr;
    logic [31:0] front_data;
    logic [31:0] halt_pc;
    integer      seed;
    int          value_errors;
    int          other_errors;
    int          stores_seen;
    int          cycles = 0;

    rv_core #(
        .reset_pc (32'h0)
    ) u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .imem_data    (imem_data),
        .imem_addr    (imem_addr),
        .store_en     (store_en),
        .store_addr   (store_addr),
        .store_data   (store_data),
        .halted       (halted),
        .illegal_inst (illegal_inst)
    );

    assign imem_data = imem[imem_addr[7:2]]; // word addressed

    always #50 clk = ~clk;

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bne_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type_word(input logic [6:0] op, input logic [4:0] rd,
                                                input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic load_program();
        logic [11:0] c1;
        logic [11:0] c2;
        logic [19:0] u1;
        logic [19:0] u2;
        logic [31:0] v1;
        logic [31:0] v2;
        c1 = 12'($random(seed));
        c2 = 12'($random(seed));
        u1 = 20'($random(seed));
        u2 = 20'($random(seed));
        if (c2 == c1) c2 = c1 ^ 12'h001; // bne must be taken
        v1 = {{20{c1[11]}}, c1};
        v2 = {{20{c2[11]}}, c2};
        // stray stores everywhere else, offset follows the address
        for (int i = 0; i < 64; i++) begin
            imem[i] = sw_word(5'd2, 5'd10, 12'(i * 4));
        end
        imem[0]  = sw_word(5'd0, 5'd0, 12'd0); // store sits at the reset pc
        imem[1]  = addi_word(5'd1, 5'd0, c1);
        imem[2]  = addi_word(5'd2, 5'd0, c2);
        imem[3]  = r_type_word(7'h00, 5'd2, 5'd1, 5'd3); // add
        imem[4]  = r_type_word(7'h20, 5'd2, 5'd1, 5'd4); // sub
        imem[5]  = addi_word(5'd10, 5'd0, 12'h100);
        imem[6]  = sw_word(5'd3, 5'd10, 12'd0);
        imem[7]  = sw_word(5'd4, 5'd10, 12'd4);
        imem[8]  = sw_word(5'd1, 5'd10, 12'd8);
        imem[9]  = u_type_word(7'b0110111, 5'd5, u1); // lui
        imem[10] = u_type_word(7'b0010111, 5'd6, u2); // auipc at pc 40
        imem[11] = sw_word(5'd5, 5'd10, 12'd12);
        imem[12] = sw_word(5'd6, 5'd10, 12'd16);
        imem[13] = bne_word(5'd1, 5'd2, 13'd8); // taken, word 14 skipped
        imem[15] = bne_word(5'd1, 5'd1, 13'd8); // not taken
        imem[16] = sw_word(5'd2, 5'd10, 12'd24);
        imem[17] = jal_word(5'd7, 21'd12); // to word 20
        imem[20] = sw_word(5'd7, 5'd10, 12'd36);
        imem[21] = addi_word(5'd11, 5'd0, 12'd100);
        imem[22] = jalr_word(5'd8, 5'd11, 12'd5); // 105, bit 0 dropped
        imem[26] = sw_word(5'd8, 5'd10, 12'd44);
        imem[27] = r_type_word(7'h01, 5'd2, 5'd1, 5'd1); // mul x1, unsupported
        imem[28] = sw_word(5'd1, 5'd10, 12'd48);
        imem[29] = 32'h0010_0073; // ebreak
        expect_store(32'h0,              32'h0);
        expect_store(base_addr,          v1 + v2);
        expect_store(base_addr + 32'd4,  v1 - v2);
        expect_store(base_addr + 32'd8,  v1);
        expect_store(base_addr + 32'd12, {u1, 12'b0});
        expect_store(base_addr + 32'd16, 32'd40 + {u2, 12'b0});
        expect_store(base_addr + 32'd24, v2);
        expect_store(base_addr + 32'd36, 32'd72);
        expect_store(base_addr + 32'd44, 32'd92);
        expect_store(base_addr + 32'd48, v1);
    endtask

    // DUT state moves in the NBA region, so these see pre-edge values
    always @(posedge clk) begin
        if (!arst_n) begin
            assert (!store_en) else begin
                $display("Store strobe was active while reset was asserted");
                other_errors++;
            end
        end else begin
            assert (illegal_inst == (imem_addr == illegal_pc)) else begin
                $display("Error: illegal_inst at pc %h expected %h actual %h", imem_addr,
                         imem_addr == illegal_pc, illegal_inst);
                value_errors++;
            end
            if (store_en) begin
                stores_seen++;
                assert (exp_addr_q.size() != 0) else begin
                    $display("Store to %h from pc %h was not expected", store_addr, imem_addr);
                    other_errors++;
                end
                if (exp_addr_q.size() != 0) begin
                    front_addr = exp_addr_q.pop_front();
                    front_data = exp_data_q.pop_front();
                    assert (store_addr == front_addr) else begin
                        $display("Error: store_addr expected %h actual %h", front_addr,
                                 store_addr);
                        value_errors++;
                    end
                    assert (store_data == front_data) else begin
                        $display("Error: store_data expected %h actual %h", front_data,
                                 store_data);
                        value_errors++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the core never halted", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        seed         = 74213;
        value_errors = 0;
        other_errors = 0;
        stores_seen  = 0;
        load_program();
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        while (!halted) @(negedge clk);
        halt_pc = imem_addr;
        assert (halt_pc == ebreak_pc) else begin
            $display("Error: imem_addr at halt expected %h actual %h", ebreak_pc, halt_pc);
            value_errors++;
        end
        assert (exp_addr_q.size() == 0) else begin
            $display("%0d expected stores never happened", exp_addr_q.size());
            other_errors++;
        end
        repeat (8) begin
            @(negedge clk);
            assert (halted) else begin
                $display("Error: halted expected %h actual %h", 1'b1, halted);
                value_errors++;
            end
            assert (imem_addr == halt_pc) else begin
                $display("Error: imem_addr expected %h actual %h", halt_pc, imem_addr);
                value_errors++;
            end
        end
        $display("value errors %0d, other errors %0d, stores seen %0d", value_errors,
                 other_errors, stores_seen);
        if (value_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
